// ==== source/ex_pkg.sv ====
/*
  Execute stage shared types: instruction word formats,
  operand mux selects, ALU function codes and branch conditions
*/
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction word, decoded as operate, memory or branch format
  //////////////////////////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] ra;
      union packed {
        struct packed {
          logic [4:0] rb;     // Register B number
          logic [2:0] sbz;    // Should be zero
        } r;
        logic [7:0] lit;      // Literal, bits 20:13
      } src;
      logic       is_lit;     // Literal flag, bit 12
      logic [6:0] func;       // Operate function
      logic [4:0] rc;         // Destination
    } op;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [4:0]  rb;        // Base register
      logic [15:0] disp;      // Signed byte offset
    } mem;
    struct packed {
      logic [5:0]  opcode;    // Low 3 bits pick the branch condition
      logic [4:0]  ra;
      logic [20:0] disp;      // Signed longword offset
    } br;
  } alpha_inst_t;

  // Operand A source
  typedef enum logic [1:0] {
    OPA_IS_REGA     = 2'd0,
    OPA_IS_MEM_DISP = 2'd1,
    OPA_IS_NPC      = 2'd2,
    OPA_IS_NOT3     = 2'd3   // Alignment mask ~3
  } opa_sel_e;

  // Operand B source, code 3 gives zero
  typedef enum logic [1:0] {
    OPB_IS_REGB    = 2'd0,
    OPB_IS_ALU_IMM = 2'd1,
    OPB_IS_BR_DISP = 2'd2
  } opb_sel_e;

  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIS    = 5'h03,   // Logical or
    ALU_XOR    = 5'h04,
    ALU_SLL    = 5'h05,
    ALU_SRL    = 5'h06,
    ALU_CMPEQ  = 5'h07,
    ALU_CMPULT = 5'h08,
    ALU_PASSA  = 5'h09,   // Link value for branches
    ALU_MULQ   = 5'h0a    // Steered to the multiplier
  } alu_func_e;

  // Instruction bits 28:26 of the branch opcodes
  typedef enum logic [2:0] {
    BLBC = 3'd0,
    BEQ  = 3'd1,
    BLT  = 3'd2,
    BLE  = 3'd3,
    BLBS = 3'd4,
    BNE  = 3'd5,
    BGE  = 3'd6,
    BGT  = 3'd7
  } brcond_e;

endpackage

// ==== source/alu.sv ====
/*
  Single-cycle 64-bit integer ALU
  Combinational, one function per ex_pkg code
*/
module alu import ex_pkg::*;
(
  input  logic [63:0] opa,
  input  logic [63:0] opb,
  input  alu_func_e   func,
  output logic [63:0] result
);

  logic [5:0] shamt;   // Shift count, low bits of opb

  assign shamt = opb[5:0];

  always_comb
  begin
    case (func)
      ALU_ADDQ:
        result = opa + opb;
      ALU_SUBQ:
        result = opa - opb;
      ALU_AND:
        result = opa & opb;
      ALU_BIS:
        result = opa | opb;
      ALU_XOR:
        result = opa ^ opb;
      ALU_SLL:
        result = opa << shamt;
      ALU_SRL:
        result = opa >> shamt;   // Logical, zero fill
      ALU_CMPEQ:
        result = {63'd0, opa == opb};
      ALU_CMPULT:
        result = {63'd0, opa < opb};   // Both unsigned
      ALU_PASSA:
        result = opa;
      default:
        result = 64'd0;   // MULQ and unused codes
    endcase
  end

endmodule

// ==== source/mult.sv ====
/*
  Pipelined 64x64 multiplier, low 64 bits of the product
  One mplier slice per stage, tags ride along with the data
*/
module mult #(
  parameter int MULT_STAGES = 4   // Must divide 64
)
(
  input  logic        clock,
  input  logic        rst_n,
  input  logic        valid_in,
  input  logic [31:0] ir_in,
  input  logic [63:0] npc_in,
  input  logic [4:0]  dest_reg_in,
  input  logic [63:0] mplier,
  input  logic [63:0] mcand,
  output logic        valid_out,
  output logic [31:0] ir_out,
  output logic [63:0] npc_out,
  output logic [4:0]  dest_reg_out,
  output logic [63:0] product
);

  localparam int SLICE = 64 / MULT_STAGES;   // mplier bits per stage

  logic [MULT_STAGES-1:0] valid_q;
  logic [63:0] partial_q [MULT_STAGES];   // Running sum
  logic [63:0] mplier_q  [MULT_STAGES-1]; // Remaining mplier bits
  logic [63:0] mcand_q   [MULT_STAGES-1]; // mcand shifted into place
  logic [31:0] ir_q      [MULT_STAGES];
  logic [63:0] npc_q     [MULT_STAGES];
  logic [4:0]  dest_q    [MULT_STAGES];

  // Add one slice times mcand to the sum
  function automatic logic [63:0] mac(input logic [63:0] acc,
                                      input logic [63:0] mpl,
                                      input logic [63:0] mcd);
    logic [63:0] digit;
    digit = {{(64-SLICE){1'b0}}, mpl[SLICE-1:0]};
    return acc + digit * mcd;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Valid chain
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= '0;
    else
      valid_q <= {valid_q[MULT_STAGES-2:0], valid_in};
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath and tags
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    partial_q[0] <= mac(64'd0, mplier, mcand);   // First slice
    mplier_q[0]  <= mplier >> SLICE;
    mcand_q[0]   <= mcand << SLICE;
    ir_q[0]      <= ir_in;
    npc_q[0]     <= npc_in;
    dest_q[0]    <= dest_reg_in;
    for (int i = 1; i < MULT_STAGES; i++)
    begin
      partial_q[i] <= mac(partial_q[i-1], mplier_q[i-1], mcand_q[i-1]);
      ir_q[i]      <= ir_q[i-1];
      npc_q[i]     <= npc_q[i-1];
      dest_q[i]    <= dest_q[i-1];
    end
    for (int i = 1; i < MULT_STAGES - 1; i++)
    begin
      mplier_q[i] <= mplier_q[i-1] >> SLICE;
      mcand_q[i]  <= mcand_q[i-1] << SLICE;
    end
  end

  assign valid_out    = valid_q[MULT_STAGES-1];
  assign ir_out       = ir_q[MULT_STAGES-1];
  assign npc_out      = npc_q[MULT_STAGES-1];
  assign dest_reg_out = dest_q[MULT_STAGES-1];
  assign product      = partial_q[MULT_STAGES-1];

endmodule

// ==== source/brcond.sv ====
/*
  Branch condition test on the register A value
*/
module brcond import ex_pkg::*;
(
  input  logic [63:0] opa,
  input  brcond_e     func,
  output logic        cond
);

  logic is_zero;
  logic is_neg;

  assign is_zero = (opa == 64'd0);
  assign is_neg  = opa[63];   // Sign bit

  always_comb
  begin
    case (func)
      BLBC:    cond = ~opa[0];
      BEQ:     cond = is_zero;
      BLT:     cond = is_neg;
      BLE:     cond = is_neg | is_zero;
      BLBS:    cond = opa[0];
      BNE:     cond = ~is_zero;
      BGE:     cond = ~is_neg;
      BGT:     cond = ~is_neg & ~is_zero;
      default: cond = 1'b0;
    endcase
  end

endmodule

// ==== source/result_arbiter.sv ====
/*
  Per-lane result merge of ALU and multiplier streams
  Multiplier has priority; a colliding ALU request is stalled
*/
module result_arbiter
(
  input  logic        clock,
  input  logic        rst_n,
  // ALU request
  input  logic        alu_valid,
  input  logic [31:0] alu_ir,
  input  logic [63:0] alu_npc,
  input  logic [4:0]  alu_dest_reg,
  input  logic [63:0] alu_result,
  input  logic        br_taken_in,
  input  logic [63:0] br_target_in,
  // Multiplier result
  input  logic        mult_valid,
  input  logic [31:0] mult_ir,
  input  logic [63:0] mult_npc,
  input  logic [4:0]  mult_dest_reg,
  input  logic [63:0] mult_result,
  // Merged output
  output logic        stall,
  output logic [31:0] ir_out,
  output logic [63:0] npc_out,
  output logic [4:0]  dest_reg_out,
  output logic [63:0] result_out,
  output logic        valid_out,
  output logic        br_taken_out,
  output logic [63:0] br_target_out
);

  logic take_alu;   // ALU request wins this cycle

  assign take_alu = alu_valid & ~mult_valid;
  assign stall    = alu_valid & mult_valid;   // Collision, hold upstream

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_out    <= 1'b0;
      br_taken_out <= 1'b0;
    end
    else
    begin
      valid_out    <= mult_valid | alu_valid;
      br_taken_out <= take_alu & br_taken_in;   // Only a taken request
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (mult_valid)
    begin
      ir_out       <= mult_ir;
      npc_out      <= mult_npc;
      dest_reg_out <= mult_dest_reg;
      result_out   <= mult_result;
    end
    else if (alu_valid)
    begin
      ir_out        <= alu_ir;
      npc_out       <= alu_npc;
      dest_reg_out  <= alu_dest_reg;
      result_out    <= alu_result;
      br_target_out <= br_target_in;   // Kept until next ALU beat
    end
  end

endmodule

// ==== source/ex_stage.sv ====
/*
  Two-lane execute stage: operand selection, ALU and pipelined
  multiplier per lane, lane-1 branch evaluation, registered outputs
*/
module ex_stage import ex_pkg::*;
#(
  parameter int MULT_STAGES = 4
)
(
  input  logic        clock,
  input  logic        rst_n,
  // Lane 1, carries branch logic
  input  logic        id_ex_valid_1,
  input  logic [63:0] id_ex_npc_1,
  input  logic [31:0] id_ex_ir_1,
  input  logic [4:0]  id_ex_dest_reg_1,
  input  logic [63:0] id_ex_rega_1,
  input  logic [63:0] id_ex_regb_1,
  input  opa_sel_e    id_ex_opa_select_1,
  input  opb_sel_e    id_ex_opb_select_1,
  input  alu_func_e   id_ex_alu_func_1,
  input  logic        id_ex_cond_branch,
  input  logic        id_ex_uncond_branch,
  // Lane 2
  input  logic        id_ex_valid_2,
  input  logic [63:0] id_ex_npc_2,
  input  logic [31:0] id_ex_ir_2,
  input  logic [4:0]  id_ex_dest_reg_2,
  input  logic [63:0] id_ex_rega_2,
  input  logic [63:0] id_ex_regb_2,
  input  opa_sel_e    id_ex_opa_select_2,
  input  opb_sel_e    id_ex_opb_select_2,
  input  alu_func_e   id_ex_alu_func_2,
  // Outputs
  output logic        stall_bus_1,
  output logic        stall_bus_2,
  output logic        ex_branch_taken,
  output logic [63:0] ex_branch_target,
  output logic [31:0] ex_ir_out_1,
  output logic [63:0] ex_npc_out_1,
  output logic [4:0]  ex_dest_reg_out_1,
  output logic [63:0] ex_result_out_1,
  output logic        ex_valid_out_1,
  output logic [31:0] ex_ir_out_2,
  output logic [63:0] ex_npc_out_2,
  output logic [4:0]  ex_dest_reg_out_2,
  output logic [63:0] ex_result_out_2,
  output logic        ex_valid_out_2
);

  alpha_inst_t inst_1, inst_2;
  logic [63:0] opa_1, opb_1, opa_2, opb_2;   // Mux outputs
  logic        alu_valid_1, alu_valid_2;
  logic        mul_valid_in_1, mul_valid_in_2;
  logic [63:0] alu_result_1, alu_result_2;
  logic        mul_valid_1, mul_valid_2;
  logic [31:0] mul_ir_1, mul_ir_2;
  logic [63:0] mul_npc_1, mul_npc_2;
  logic [4:0]  mul_dest_1, mul_dest_2;
  logic [63:0] mul_result_1, mul_result_2;
  logic        brcond_result;
  logic        branch_taken;
  logic [63:0] branch_target;

  //////////////////////////////////////////////////////////////////////
  // Immediates and operand muxes
  //////////////////////////////////////////////////////////////////////
  function automatic logic [63:0] mem_disp(input alpha_inst_t inst);
    return {{48{inst.mem.disp[15]}}, inst.mem.disp};   // Sign-extended
  endfunction

  function automatic logic [63:0] br_disp(input alpha_inst_t inst);
    return {{41{inst.br.disp[20]}}, inst.br.disp, 2'b00};   // Times 4
  endfunction

  function automatic logic [63:0] opa_mux(input opa_sel_e    sel,
                                          input logic [63:0] rega,
                                          input logic [63:0] npc,
                                          input alpha_inst_t inst);
    case (sel)
      OPA_IS_REGA:     return rega;
      OPA_IS_MEM_DISP: return mem_disp(inst);
      OPA_IS_NPC:      return npc;
      default:         return ~64'h3;   // NOT3 alignment mask
    endcase
  endfunction

  function automatic logic [63:0] opb_mux(input opb_sel_e    sel,
                                          input logic [63:0] regb,
                                          input alpha_inst_t inst);
    case (sel)
      OPB_IS_REGB:    return regb;
      OPB_IS_ALU_IMM: return {56'd0, inst.op.src.lit};   // Zero-extended
      OPB_IS_BR_DISP: return br_disp(inst);
      default:        return 64'd0;
    endcase
  endfunction

  assign inst_1 = id_ex_ir_1;
  assign inst_2 = id_ex_ir_2;
  assign opa_1  = opa_mux(id_ex_opa_select_1, id_ex_rega_1, id_ex_npc_1, inst_1);
  assign opb_1  = opb_mux(id_ex_opb_select_1, id_ex_regb_1, inst_1);
  assign opa_2  = opa_mux(id_ex_opa_select_2, id_ex_rega_2, id_ex_npc_2, inst_2);
  assign opb_2  = opb_mux(id_ex_opb_select_2, id_ex_regb_2, inst_2);

  // Steer MULQ to the multiplier, everything else to the ALU
  assign mul_valid_in_1 = id_ex_valid_1 & (id_ex_alu_func_1 == ALU_MULQ);
  assign mul_valid_in_2 = id_ex_valid_2 & (id_ex_alu_func_2 == ALU_MULQ);
  assign alu_valid_1    = id_ex_valid_1 & (id_ex_alu_func_1 != ALU_MULQ);
  assign alu_valid_2    = id_ex_valid_2 & (id_ex_alu_func_2 != ALU_MULQ);

  // Lane 1 branch resolution
  assign branch_target = id_ex_npc_1 + br_disp(inst_1);
  assign branch_taken  = id_ex_uncond_branch | (id_ex_cond_branch & brcond_result);

  //////////////////////////////////////////////////////////////////////
  // Execution units
  //////////////////////////////////////////////////////////////////////
  alu u_alu_1 (.opa(opa_1), .opb(opb_1), .func(id_ex_alu_func_1), .result(alu_result_1));
  alu u_alu_2 (.opa(opa_2), .opb(opb_2), .func(id_ex_alu_func_2), .result(alu_result_2));

  brcond u_brcond (
    .opa  (id_ex_rega_1),                       // Always register A
    .func (brcond_e'(inst_1.br.opcode[2:0])),   // Bits 28:26
    .cond (brcond_result)
  );

  mult #(.MULT_STAGES(MULT_STAGES)) u_mult_1 (
    .clock(clock), .rst_n(rst_n), .valid_in(mul_valid_in_1),
    .ir_in(id_ex_ir_1), .npc_in(id_ex_npc_1), .dest_reg_in(id_ex_dest_reg_1),
    .mplier(opa_1), .mcand(opb_1),
    .valid_out(mul_valid_1), .ir_out(mul_ir_1), .npc_out(mul_npc_1),
    .dest_reg_out(mul_dest_1), .product(mul_result_1)
  );

  mult #(.MULT_STAGES(MULT_STAGES)) u_mult_2 (
    .clock(clock), .rst_n(rst_n), .valid_in(mul_valid_in_2),
    .ir_in(id_ex_ir_2), .npc_in(id_ex_npc_2), .dest_reg_in(id_ex_dest_reg_2),
    .mplier(opa_2), .mcand(opb_2),
    .valid_out(mul_valid_2), .ir_out(mul_ir_2), .npc_out(mul_npc_2),
    .dest_reg_out(mul_dest_2), .product(mul_result_2)
  );

  //////////////////////////////////////////////////////////////////////
  // Result merge, one arbiter per lane
  //////////////////////////////////////////////////////////////////////
  result_arbiter u_arb_1 (
    .clock(clock), .rst_n(rst_n),
    .alu_valid(alu_valid_1), .alu_ir(id_ex_ir_1), .alu_npc(id_ex_npc_1),
    .alu_dest_reg(id_ex_dest_reg_1), .alu_result(alu_result_1),
    .br_taken_in(branch_taken), .br_target_in(branch_target),
    .mult_valid(mul_valid_1), .mult_ir(mul_ir_1), .mult_npc(mul_npc_1),
    .mult_dest_reg(mul_dest_1), .mult_result(mul_result_1),
    .stall(stall_bus_1), .ir_out(ex_ir_out_1), .npc_out(ex_npc_out_1),
    .dest_reg_out(ex_dest_reg_out_1), .result_out(ex_result_out_1),
    .valid_out(ex_valid_out_1),
    .br_taken_out(ex_branch_taken), .br_target_out(ex_branch_target)
  );

  result_arbiter u_arb_2 (
    .clock(clock), .rst_n(rst_n),
    .alu_valid(alu_valid_2), .alu_ir(id_ex_ir_2), .alu_npc(id_ex_npc_2),
    .alu_dest_reg(id_ex_dest_reg_2), .alu_result(alu_result_2),
    .br_taken_in(1'b0), .br_target_in(64'd0),   // No branches on lane 2
    .mult_valid(mul_valid_2), .mult_ir(mul_ir_2), .mult_npc(mul_npc_2),
    .mult_dest_reg(mul_dest_2), .mult_result(mul_result_2),
    .stall(stall_bus_2), .ir_out(ex_ir_out_2), .npc_out(ex_npc_out_2),
    .dest_reg_out(ex_dest_reg_out_2), .result_out(ex_result_out_2),
    .valid_out(ex_valid_out_2),
    .br_taken_out(), .br_target_out()
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
  Testbench clock and reset source
  Period 10, rst_n low for the first 8 rising edges
*/
module tb_clock_gen
(
  output logic clock,
  output logic rst_n
);

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (8) @(posedge clock);
    rst_n <= 1'b1;   // Released on the 8th edge
  end

endmodule

// ==== testbench/ex_stage_chk.sv ====
/*
  Protocol and latency assertions for the execute stage
  Attached to every ex_stage instance by bind
*/
module ex_stage_chk import ex_pkg::*;
#(
  parameter int MULT_STAGES = 4
)
(
  input logic        clock,
  input logic        rst_n,
  input logic        id_ex_valid_1, id_ex_valid_2,
  input alu_func_e   id_ex_alu_func_1, id_ex_alu_func_2,
  input logic [31:0] id_ex_ir_1, id_ex_ir_2,
  input logic [63:0] id_ex_rega_1, id_ex_rega_2,
  input logic [63:0] id_ex_regb_1, id_ex_regb_2,
  input logic        stall_bus_1, stall_bus_2,
  input logic [63:0] opa_1, opb_1, opa_2, opb_2,
  input logic        ex_valid_out_1, ex_valid_out_2,
  input logic [63:0] ex_result_out_1, ex_result_out_2,
  input logic        ex_branch_taken
);

  int fail_count = 0;   // Read by the testbench
  logic        mulq_1, mulq_2;
  logic [63:0] prod_1, prod_2;

  assign mulq_1 = id_ex_valid_1 && (id_ex_alu_func_1 == ALU_MULQ);
  assign mulq_2 = id_ex_valid_2 && (id_ex_alu_func_2 == ALU_MULQ);
  assign prod_1 = opa_1 * opb_1;   // Low 64 bits
  assign prod_2 = opa_2 * opb_2;

  //////////////////////////////////////////////////////////////////////
  // Reset and stall rules
  //////////////////////////////////////////////////////////////////////
  a_reset_quiet: assert property (@(posedge clock)
    !rst_n |-> !(ex_valid_out_1 || ex_valid_out_2 || ex_branch_taken))
    else begin $error("outputs active during reset"); fail_count++; end

  // A mult result is due MULT_STAGES edges after its MULQ
  a_stall_1: assert property (@(posedge clock) disable iff (!rst_n)
    stall_bus_1 |-> $past(mulq_1, MULT_STAGES))
    else begin $error("lane 1 stall without mult result"); fail_count++; end
  a_stall_2: assert property (@(posedge clock) disable iff (!rst_n)
    stall_bus_2 |-> $past(mulq_2, MULT_STAGES))
    else begin $error("lane 2 stall without mult result"); fail_count++; end

  // Upstream keeps a stalled request
  a_hold_1: assert property (@(posedge clock) disable iff (!rst_n)
    stall_bus_1 |=> id_ex_valid_1 && $stable(id_ex_ir_1) &&
                    $stable(id_ex_rega_1) && $stable(id_ex_regb_1))
    else begin $error("lane 1 stalled request changed"); fail_count++; end
  a_hold_2: assert property (@(posedge clock) disable iff (!rst_n)
    stall_bus_2 |=> id_ex_valid_2 && $stable(id_ex_ir_2) &&
                    $stable(id_ex_rega_2) && $stable(id_ex_regb_2))
    else begin $error("lane 2 stalled request changed"); fail_count++; end

  //////////////////////////////////////////////////////////////////////
  // Multiplier latency and value
  //////////////////////////////////////////////////////////////////////
  a_mulq_1: assert property (@(posedge clock) disable iff (!rst_n)
    mulq_1 |-> ##(MULT_STAGES+1)
      (ex_valid_out_1 && ex_result_out_1 == $past(prod_1, MULT_STAGES+1)))
    else begin $error("lane 1 MULQ result late or wrong"); fail_count++; end
  a_mulq_2: assert property (@(posedge clock) disable iff (!rst_n)
    mulq_2 |-> ##(MULT_STAGES+1)
      (ex_valid_out_2 && ex_result_out_2 == $past(prod_2, MULT_STAGES+1)))
    else begin $error("lane 2 MULQ result late or wrong"); fail_count++; end

  a_taken_valid: assert property (@(posedge clock) disable iff (!rst_n)
    ex_branch_taken |-> ex_valid_out_1)
    else begin $error("branch taken without lane 1 valid"); fail_count++; end

endmodule

bind ex_stage ex_stage_chk #(.MULT_STAGES(MULT_STAGES)) u_chk (.*);

// ==== testbench/ex_stage_tb.sv ====
/*
  Execute stage testbench with per-lane scoreboards keyed by output cycle,
  stall-aware issue of operation queues and per-test report lines
*/
module ex_stage_tb import ex_pkg::*;
();

  localparam int MS        = 4;                     // Multiplier depth
  localparam int TOTAL_OPS = 90;                    // All tests together
  localparam int LIMIT     = TOTAL_OPS * (MS + 3) + 200;

  typedef struct packed {
    logic        valid;
    logic [31:0] ir;
    logic [63:0] npc;
    logic [4:0]  dest;
    logic [63:0] rega, regb;
    opa_sel_e    opa_sel;
    opb_sel_e    opb_sel;
    alu_func_e   func;
    logic        cond, uncond;
    logic [63:0] result;   // Expected values from here on
    logic        taken;
    logic [63:0] target;
  } op_t;

  logic clock, rst_n;
  logic id_ex_valid_1, id_ex_valid_2, id_ex_cond_branch, id_ex_uncond_branch;
  logic [63:0] id_ex_npc_1, id_ex_npc_2, id_ex_rega_1, id_ex_rega_2;
  logic [63:0] id_ex_regb_1, id_ex_regb_2;
  logic [31:0] id_ex_ir_1, id_ex_ir_2;
  logic [4:0]  id_ex_dest_reg_1, id_ex_dest_reg_2;
  opa_sel_e    id_ex_opa_select_1, id_ex_opa_select_2;
  opb_sel_e    id_ex_opb_select_1, id_ex_opb_select_2;
  alu_func_e   id_ex_alu_func_1, id_ex_alu_func_2;
  logic stall_bus_1, stall_bus_2, ex_branch_taken, ex_valid_out_1, ex_valid_out_2;
  logic [63:0] ex_branch_target, ex_npc_out_1, ex_npc_out_2;
  logic [63:0] ex_result_out_1, ex_result_out_2;
  logic [31:0] ex_ir_out_1, ex_ir_out_2;
  logic [4:0]  ex_dest_reg_out_1, ex_dest_reg_out_2;

  op_t q1[$], q2[$];       // Waiting to issue
  op_t exp1[int], exp2[int];   // Keyed by output cycle
  int  cyc = 0, errors = 0, tests = 0, failed = 0, stalls1, stalls2, e0;
  logic [31:0] lcg_state = 32'h51fb_0c1c;

  tb_clock_gen u_clk (.clock(clock), .rst_n(rst_n));

  ex_stage #(.MULT_STAGES(MS)) u_dut (.*);

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rnd64();
    return {lcg(), lcg()};
  endfunction

  function automatic logic branch_ref(logic [2:0] c, logic [63:0] a);
    case (c)
      3'd0: return !a[0];               // BLBC
      3'd1: return a == 0;              // BEQ
      3'd2: return $signed(a) < 0;
      3'd3: return $signed(a) <= 0;
      3'd4: return a[0];                // BLBS
      3'd5: return a != 0;
      3'd6: return $signed(a) >= 0;
      default: return $signed(a) > 0;   // BGT
    endcase
  endfunction

  function automatic op_t make_op(alu_func_e f, opa_sel_e sa, opb_sel_e sb,
                                  logic [31:0] ir, logic [63:0] a, logic [63:0] b,
                                  logic c, logic u);
    op_t o;
    logic [63:0] x, y, bdisp;
    o = '0;
    o.valid   = 1'b1;
    o.func    = f;
    o.ir      = ir;
    o.opa_sel = sa;
    o.opb_sel = sb;
    o.rega    = a;
    o.regb    = b;
    o.cond    = c;
    o.uncond  = u;
    o.npc  = rnd64() & ~64'd3;
    o.dest = ir[4:0];
    bdisp  = 64'($signed(ir[20:0])) << 2;   // Longwords to bytes
    case (sa)
      OPA_IS_REGA:     x = a;
      OPA_IS_MEM_DISP: x = 64'($signed(ir[15:0]));
      OPA_IS_NPC:      x = o.npc;
      default:         x = 64'hffff_ffff_ffff_fffc;
    endcase
    case (sb)
      OPB_IS_REGB:    y = b;
      OPB_IS_ALU_IMM: y = {56'd0, ir[20:13]};
      OPB_IS_BR_DISP: y = bdisp;
      default:        y = 64'd0;
    endcase
    case (f)
      ALU_ADDQ:   o.result = x + y;
      ALU_SUBQ:   o.result = x - y;
      ALU_AND:    o.result = x & y;
      ALU_BIS:    o.result = x | y;
      ALU_XOR:    o.result = x ^ y;
      ALU_SLL:    o.result = x << y[5:0];
      ALU_SRL:    o.result = x >> y[5:0];
      ALU_CMPEQ:  o.result = (x == y) ? 64'd1 : 64'd0;
      ALU_CMPULT: o.result = (x < y) ? 64'd1 : 64'd0;
      ALU_PASSA:  o.result = x;
      ALU_MULQ:   o.result = x * y;
      default:    o.result = 64'd0;
    endcase
    o.taken  = u | (c & branch_ref(ir[28:26], a));
    o.target = o.npc + bdisp;
    return o;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Issue and output checking
  //////////////////////////////////////////////////////////////////////
  task automatic drive(input op_t a, input op_t b);
    id_ex_valid_1       <= a.valid;
    id_ex_npc_1         <= a.npc;
    id_ex_ir_1          <= a.ir;
    id_ex_dest_reg_1    <= a.dest;
    id_ex_rega_1        <= a.rega;
    id_ex_regb_1        <= a.regb;
    id_ex_opa_select_1  <= a.opa_sel;
    id_ex_opb_select_1  <= a.opb_sel;
    id_ex_alu_func_1    <= a.func;
    id_ex_cond_branch   <= a.cond;
    id_ex_uncond_branch <= a.uncond;
    id_ex_valid_2       <= b.valid;
    id_ex_npc_2         <= b.npc;
    id_ex_ir_2          <= b.ir;
    id_ex_dest_reg_2    <= b.dest;
    id_ex_rega_2        <= b.rega;
    id_ex_regb_2        <= b.regb;
    id_ex_opa_select_2  <= b.opa_sel;
    id_ex_opb_select_2  <= b.opb_sel;
    id_ex_alu_func_2    <= b.func;
  endtask

  // Heads stay on the bus until accepted
  task automatic run_queues();
    op_t h1, h2;
    while (q1.size() != 0 || q2.size() != 0)
    begin
      h1 = (q1.size() != 0) ? q1[0] : op_t'('0);
      h2 = (q2.size() != 0) ? q2[0] : op_t'('0);
      drive(h1, h2);
      @(negedge clock);
      if (stall_bus_1)
        stalls1++;
      if (stall_bus_2)
        stalls2++;
      if (q1.size() != 0 && !(h1.valid && stall_bus_1))
      begin
        if (h1.valid)
          exp1[cyc + ((h1.func == ALU_MULQ) ? MS + 1 : 1)] = h1;
        void'(q1.pop_front());
      end
      if (q2.size() != 0 && !(h2.valid && stall_bus_2))
      begin
        if (h2.valid)
          exp2[cyc + ((h2.func == ALU_MULQ) ? MS + 1 : 1)] = h2;
        void'(q2.pop_front());
      end
      @(posedge clock);
    end
    drive(op_t'('0), op_t'('0));
    repeat (MS + 3) @(posedge clock);   // Drain
    if (exp1.size() != 0 || exp2.size() != 0)
    begin
      $display("Expected results never appeared at time %0t", $time);
      errors++;
    end
  endtask

  task automatic compare(input string name, input logic [63:0] exp_v,
                         input logic [63:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_beat(input int lane, input logic v, input logic [31:0] ir,
                            input logic [63:0] npc, input logic [4:0] dest,
                            input logic [63:0] res);
    op_t e;
    logic hit;
    hit = (lane == 1) ? exp1.exists(cyc) : exp2.exists(cyc);
    if (hit)
      e = (lane == 1) ? exp1[cyc] : exp2[cyc];
    if (lane == 1 && hit)
      exp1.delete(cyc);
    if (lane == 2 && hit)
      exp2.delete(cyc);
    if (v && !hit)
    begin
      $display("Lane %0d gave an unexpected result at time %0t", lane, $time);
      errors++;
    end
    else if (!v && hit)
    begin
      $display("Lane %0d result missing at time %0t", lane, $time);
      errors++;
    end
    else if (v)
    begin
      compare($sformatf("ex_ir_out_%0d", lane), e.ir, ir);
      compare($sformatf("ex_npc_out_%0d", lane), e.npc, npc);
      compare($sformatf("ex_dest_reg_out_%0d", lane), e.dest, dest);
      compare($sformatf("ex_result_out_%0d", lane), e.result, res);
      if (lane == 1)
        compare("ex_branch_taken", e.taken, ex_branch_taken);
      if (lane == 1 && (e.cond || e.uncond))
        compare("ex_branch_target", e.target, ex_branch_target);
    end
  endtask

  always @(posedge clock)
  begin
    cyc <= cyc + 1;
    if (cyc > LIMIT)
    begin
      $display("Timeout: run exceeded %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  always @(negedge clock)
  begin
    if (rst_n)
    begin
      check_beat(1, ex_valid_out_1, ex_ir_out_1, ex_npc_out_1, ex_dest_reg_out_1,
                 ex_result_out_1);
      check_beat(2, ex_valid_out_2, ex_ir_out_2, ex_npc_out_2, ex_dest_reg_out_2,
                 ex_result_out_2);
    end
  end

  task automatic report(input string name);
    tests++;
    if (errors != e0)
      failed++;
    $display("test %s %s", name, (errors == e0) ? "ok" : "FAILED");
    e0 = errors;
    stalls1 = 0;
    stalls2 = 0;
  endtask

  task automatic collide_pattern(input op_t alu_op, input int lane);
    op_t m;
    m = make_op(ALU_MULQ, OPA_IS_REGA, OPB_IS_REGB, lcg(), rnd64(), rnd64(), 0, 0);
    if (lane == 1)
    begin
      q1.push_back(m);
      repeat (MS - 1) q1.push_back(op_t'('0));   // ALU lands on the result cycle
      q1.push_back(alu_op);
    end
    else
    begin
      q2.push_back(m);
      repeat (MS - 1) q2.push_back(op_t'('0));
      q2.push_back(alu_op);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    logic [63:0] v;
    logic [31:0] ir;
    logic [31:0] r;
    drive(op_t'('0), op_t'('0));
    e0 = 0;
    stalls1 = 0;
    stalls2 = 0;
    while (!rst_n) @(posedge clock);
    @(posedge clock);

    // Idle after reset
    repeat (6)
    begin
      @(negedge clock);
      if (ex_valid_out_1 || ex_valid_out_2 || ex_branch_taken || stall_bus_1 ||
          stall_bus_2)
      begin
        $display("Output or stall active while idle at time %0t", $time);
        errors++;
      end
    end
    @(posedge clock);
    report("reset");

    for (int f = 0; f < 10; f++)
    begin
      q1.push_back(make_op(alu_func_e'(f), OPA_IS_REGA, OPB_IS_REGB, lcg(),
                           rnd64(), rnd64(), 0, 0));
      q2.push_back(make_op(alu_func_e'(f), OPA_IS_REGA, OPB_IS_REGB, lcg(),
                           rnd64(), rnd64(), 0, 0));
    end
    v = rnd64();
    q1.push_back(make_op(ALU_CMPEQ, OPA_IS_REGA, OPB_IS_REGB, lcg(), v, v, 0, 0));
    run_queues();
    report("alu");

    q1.push_back(make_op(ALU_ADDQ, OPA_IS_REGA, OPB_IS_ALU_IMM, lcg() | 32'h0010_1000,
                         rnd64(), rnd64(), 0, 0));   // Literal with top bit set
    q1.push_back(make_op(ALU_ADDQ, OPA_IS_MEM_DISP, OPB_IS_REGB, {lcg()} | 32'h8000,
                         rnd64(), rnd64(), 0, 0));   // Negative displacement
    q2.push_back(make_op(ALU_ADDQ, OPA_IS_MEM_DISP, OPB_IS_REGB, {lcg()} & ~32'h8000,
                         rnd64(), rnd64(), 0, 0));
    q2.push_back(make_op(ALU_PASSA, OPA_IS_NPC, OPB_IS_REGB, lcg(), rnd64(), rnd64(), 0, 0));
    q1.push_back(make_op(ALU_AND, OPA_IS_NOT3, OPB_IS_REGB, lcg(), rnd64(), rnd64(), 0, 0));
    q2.push_back(make_op(ALU_ADDQ, OPA_IS_REGA, opb_sel_e'(2'd3), lcg(), rnd64(),
                         rnd64(), 0, 0));   // Unused opb code
    run_queues();
    report("operands");

    repeat (6)
    begin
      q1.push_back(make_op(ALU_MULQ, OPA_IS_REGA, OPB_IS_REGB, lcg(), rnd64(), rnd64(), 0, 0));
      q2.push_back(make_op(ALU_MULQ, OPA_IS_REGA, OPB_IS_REGB, lcg(), rnd64(), rnd64(), 0, 0));
    end
    run_queues();
    report("mult");

    collide_pattern(make_op(ALU_SUBQ, OPA_IS_REGA, OPB_IS_REGB, lcg(), rnd64(),
                            rnd64(), 0, 0), 1);
    collide_pattern(make_op(ALU_XOR, OPA_IS_REGA, OPB_IS_REGB, lcg(), rnd64(),
                            rnd64(), 0, 0), 2);
    run_queues();
    if (stalls1 != 1 || stalls2 != 1)
    begin
      $display("Collision gave %0d and %0d stall cycles, one per lane due", stalls1,
               stalls2);
      errors++;
    end
    report("collision");

    // Zero, negative, odd and even register A per condition
    for (int c = 0; c < 8; c++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        v  = (k == 0) ? 64'd0 : (k == 1) ? (rnd64() | 64'h8000_0000_0000_0000) :
             (k == 2) ? ((rnd64() >> 1) | 64'd1) : ((rnd64() >> 1) & ~64'd1);
        r  = lcg();
        ir = {3'b111, c[2:0], r[25:0]};
        q1.push_back(make_op(ALU_PASSA, OPA_IS_NPC, OPB_IS_BR_DISP, ir, v, rnd64(), 1, 0));
      end
    end
    repeat (2)
    begin
      r = lcg();
      q1.push_back(make_op(ALU_PASSA, OPA_IS_NPC, OPB_IS_BR_DISP, {6'h30, r[25:0]},
                           rnd64(), rnd64(), 0, 1));
    end
    run_queues();
    r = lcg();
    collide_pattern(make_op(ALU_PASSA, OPA_IS_NPC, OPB_IS_BR_DISP, {6'h30, r[25:0]},
                            rnd64(), rnd64(), 0, 1), 1);
    run_queues();
    if (stalls1 != 1)
    begin
      $display("Stalled branch saw %0d stall cycles instead of one", stalls1);
      errors++;
    end
    report("branch");

    errors = errors + u_dut.u_chk.fail_count;
    $display("tests %0d, failing %0d, errors %0d, assertion failures %0d", tests, failed,
             errors, u_dut.u_chk.fail_count);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== filelist.f ====
source/ex_pkg.sv
source/alu.sv
source/mult.sv
source/brcond.sv
source/result_arbiter.sv
source/ex_stage.sv
testbench/tb_clock_gen.sv
testbench/ex_stage_chk.sv
testbench/ex_stage_tb.sv
